// ==== common/clkgen_pkg.sv ====
// shared sizes, register map, sequencer timing and config word views, imported by every block
`default_nettype none

package clkgen_pkg;

   // ########################################################################
   // sizes
   // ########################################################################

   localparam int NIN    = 2;   // reference clocks
   localparam int NOUT   = 2;   // output clocks
   localparam int DIVW   = 8;   // divin, divfb, divfrac, divout
   localparam int PHASEW = 8;   // phase shift, in vco cycles
   localparam int REG_W  = 32;
   localparam int ADDR_W = 4;

   // register map
   localparam logic [ADDR_W-1:0] ADDR_DIV   = 4'd0;
   localparam logic [ADDR_W-1:0] ADDR_OUT   = 4'd1;
   localparam logic [ADDR_W-1:0] ADDR_CTRL  = 4'd2;  // start, bypass, clksel
   localparam logic [ADDR_W-1:0] ADDR_STAT  = 4'd3;  // read only
   localparam logic [ADDR_W-1:0] ADDR_FREQ0 = 4'd4;  // read only
   localparam logic [ADDR_W-1:0] ADDR_FREQ1 = 4'd5;  // read only

   // values after rst_n
   localparam logic [REG_W-1:0] DIV_RST    = 32'h0000_0101;  // divin 1, divfb 1
   localparam logic [REG_W-1:0] OUT_RST    = 32'h0000_0101;  // divout 1/1, no phase
   localparam logic [NIN-1:0]   CLKSEL_RST = 2'b01;          // clkin[0]

   // ########################################################################
   // timing
   // ########################################################################

   localparam int RST_CYCLES   = 8;    // pll reset hold, system clocks
   localparam int LOCK_TIMEOUT = 512;  // lock budget, system clocks
   localparam int FLOCK_CYCLES = 64;   // vco cycles to freqlock
   localparam int PLOCK_CYCLES = 16;   // further vco cycles to phaselock
   localparam int WINDOW       = 256;  // meter window, system clocks
   localparam int CNT_W        = 10;   // meter count width

   // derived counter widths
   localparam int LOCK_W = $clog2(FLOCK_CYCLES + PLOCK_CYCLES + 1);
   localparam int SEQ_W  = $clog2(LOCK_TIMEOUT);
   localparam int WIN_W  = $clog2(WINDOW);

   // sequencer state encoding
   localparam int ST_W = 3;
   localparam logic [ST_W-1:0] ST_IDLE   = 3'd0;
   localparam logic [ST_W-1:0] ST_RESET  = 3'd1;
   localparam logic [ST_W-1:0] ST_WAIT   = 3'd2;
   localparam logic [ST_W-1:0] ST_LOCKED = 3'd3;
   localparam logic [ST_W-1:0] ST_FAULT  = 3'd4;

   // ########################################################################
   // config word, decoded by address
   // ########################################################################

   typedef struct packed {
      logic [7:0]      rsvd;
      logic [DIVW-1:0] divfrac;
      logic [DIVW-1:0] divfb;
      logic [DIVW-1:0] divin;    // lsb byte
   } div_cfg_s;

   typedef struct packed {
      logic [PHASEW-1:0] phase1;
      logic [PHASEW-1:0] phase0;
      logic [DIVW-1:0]   divout1;
      logic [DIVW-1:0]   divout0;  // lsb byte
   } out_cfg_s;

   typedef union packed {
      div_cfg_s div;   // word at ADDR_DIV
      out_cfg_s out;   // word at ADDR_OUT
   } cfg_word_u;

endpackage

`default_nettype wire

// ==== pll/la_pll.sv ====
// coarse pll model with ref mux, bypass, output dividers, phase delay and lock counters
`timescale 1ns/1ps
`default_nettype none

module la_pll (
   input  logic [clkgen_pkg::NIN-1:0]  clkin,      // reference clocks
   input  logic [clkgen_pkg::NIN-1:0]  clksel,     // one hot
   input  logic                        reset,      // active high
   input  logic                        en,
   input  logic                        bypass,
   input  clkgen_pkg::cfg_word_u       div_cfg,    // loop dividers, not modeled
   input  clkgen_pkg::cfg_word_u       out_cfg,    // divout and phase per output
   output logic                        clkvco,
   output logic [clkgen_pkg::NOUT-1:0] clkout,
   output logic                        freqlock,
   output logic                        phaselock
);
   import clkgen_pkg::*;

   logic                        clk_ref;   // selected reference
   logic                        ref_ok;    // some reference picked
   logic [LOCK_W-1:0]           lock_cnt;
   logic [NOUT-1:0][DIVW-1:0]   divout;
   logic [NOUT-1:0][PHASEW-1:0] phase;

   // ########################################################################
   // reference mux and vco
   // ########################################################################

   assign clk_ref = |(clkin & clksel);
   assign ref_ok  = |clksel;
   assign clkvco  = clk_ref & en & ~reset;   // n/m = 1
   // div_cfg (divin/divfb/divfrac) has no effect here, vco tracks the reference

   // lock counters run on vco edges only
   always_ff @(posedge clk_ref) begin
      if (reset || !en) begin
         lock_cnt <= '0;
      end else if (lock_cnt != LOCK_W'(FLOCK_CYCLES + PLOCK_CYCLES)) begin
         lock_cnt <= lock_cnt + 1'b1;
      end
   end

   // flags drop at once if the reference goes away
   assign freqlock  = ref_ok && (lock_cnt >= LOCK_W'(FLOCK_CYCLES));
   assign phaselock = ref_ok && (lock_cnt == LOCK_W'(FLOCK_CYCLES + PLOCK_CYCLES));

   // ########################################################################
   // output dividers
   // ########################################################################

   assign divout[0] = out_cfg.out.divout0;
   assign divout[1] = out_cfg.out.divout1;
   assign phase[0]  = out_cfg.out.phase0;
   assign phase[1]  = out_cfg.out.phase1;

   for (genvar i = 0; i < NOUT; i++) begin : g_out
      logic [DIVW-1:0]   div_n;     // zero taken as one
      logic [DIVW-1:0]   div_cnt;
      logic [PHASEW-1:0] dly_cnt;
      logic              started;   // phase delay done
      logic              div_q;

      assign div_n = (divout[i] == '0) ? DIVW'(1) : divout[i];

      always_ff @(posedge clk_ref) begin
         if (reset || !en) begin
            dly_cnt <= '0;
            started <= 1'b0;
            div_cnt <= '0;
            div_q   <= 1'b0;
         end else if (!started) begin
            // hold off the divider for phase vco cycles
            if (dly_cnt == phase[i]) begin
               started <= 1'b1;
            end else begin
               dly_cnt <= dly_cnt + 1'b1;
            end
         end else begin
            div_q   <= (div_cnt < (div_n >> 1));   // high for first half
            div_cnt <= (div_cnt >= div_n - 1'b1) ? '0 : div_cnt + 1'b1;
         end
      end

      // divide by one passes the vco through
      assign clkout[i] = bypass                ? clk_ref :
                         (div_n == DIVW'(1))   ? (clkvco & started) :
                                                 div_q;
   end

endmodule

`default_nettype wire

// ==== tb/clkgen_trace.txt ====
# kind addr data expect, all hex. kinds are wr, rd, fq (count within one), wait, poll
# wait idles for data clocks, poll rereads addr until (rdata & data) == expect
rd   0 00000000 00000101
rd   1 00000000 00000101
rd   2 00000000 00000004
rd   3 00000000 00000000
fq   4 00000000 00000000
wr   0 00a53c12 00000000
rd   0 00000000 00a53c12
wr   1 02010402 00000000
rd   1 00000000 02010402
wr   2 00000005 00000000
poll 3 00000001 00000001
rd   3 00000000 00000007
wait 0 00000258 00000000
fq   4 00000000 00000080
fq   5 00000000 00000040
wr   2 00000008 00000000
wait 0 00000258 00000000
fq   4 00000000 00000040
fq   5 00000000 00000020
rd   3 00000000 00000007
wr   2 0000000a 00000000
wait 0 00000258 00000000
fq   4 00000000 00000080
fq   5 00000000 00000080
wr   2 00000000 00000000
wait 0 00000010 00000000
rd   3 00000000 00000010
wr   2 00000005 00000000
poll 3 00000001 00000001
rd   3 00000000 00000007

// ==== tb/tb_clkgen.sv ====
// trace driven testbench for clkgen_top that is started from the project root to find its trace
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen;
   import clkgen_pkg::*;

   localparam int MAX_OPS  = 64;
   localparam int OP_WR    = 0;   // register write
   localparam int OP_RD    = 1;   // read and compare the full word
   localparam int OP_FQ    = 2;   // read and compare a count within one
   localparam int OP_WAIT  = 3;   // idle clocks
   localparam int OP_POLL  = 4;   // read until masked value matches
   localparam int POLL_MAX = (RST_CYCLES + LOCK_TIMEOUT) / 2 + 8;   // reads of 2 clocks each

   logic              clk;
   logic              clk_half;   // clkin[1]
   logic              rst_n;
   logic [NIN-1:0]    clkin;
   logic              wr_en;
   logic              rd_en;
   logic [ADDR_W-1:0] addr;
   logic [REG_W-1:0]  wdata;
   logic [REG_W-1:0]  rdata;
   logic [NOUT-1:0]   clkout;

   // trace contents with one entry per operation
   int                n_ops;
   int                op_kind [MAX_OPS];
   int                op_line [MAX_OPS];
   logic [ADDR_W-1:0] op_addr [MAX_OPS];
   logic [REG_W-1:0]  op_data [MAX_OPS];
   logic [REG_W-1:0]  op_exp  [MAX_OPS];

   int                checks;
   int                value_errs;   // wrong read values
   int                other_errs;   // trace, poll and watchdog trouble
   int                budget;       // watchdog limit in clocks
   logic              budget_ready;

   clkgen_top i_clkgen_top (
      .clk    (clk),
      .rst_n  (rst_n),
      .clkin  (clkin),
      .wr_en  (wr_en),
      .rd_en  (rd_en),
      .addr   (addr),
      .wdata  (wdata),
      .rdata  (rdata),
      .clkout (clkout)
   );

   // ########################################################################
   // clocks
   // ########################################################################

   always #10 clk = ~clk;                                 // 20 ns
   always @(posedge clk) clk_half <= ~clk_half;           // half rate ref
   assign clkin = {clk_half, clk};

   // ########################################################################
   // register bus
   // ########################################################################

   task automatic reg_write(input logic [ADDR_W-1:0] a, input logic [REG_W-1:0] d);
      @(posedge clk);
      wr_en <= 1'b1;
      addr  <= a;
      wdata <= d;
      @(posedge clk);   // write lands here
      wr_en <= 1'b0;
   endtask

   task automatic reg_read(input logic [ADDR_W-1:0] a, output logic [REG_W-1:0] d);
      @(posedge clk);
      rd_en <= 1'b1;
      addr  <= a;
      @(posedge clk);   // rdata captured on this edge
      rd_en <= 1'b0;
      @(negedge clk);   // stable mid cycle
      d = rdata;
   endtask

   // rising edges on one clkout pin over a window, sampled mid cycle
   task automatic count_pin_edges(input int idx, output logic [CNT_W-1:0] n);
      logic prev;
      logic cur;
      n = '0;
      @(negedge clk);
      prev = clkout[idx];
      repeat (WINDOW) begin
         @(negedge clk);
         cur = clkout[idx];
         if (cur && !prev) begin
            n = n + 1'b1;
         end
         prev = cur;
      end
   endtask

   // ########################################################################
   // compares
   // ########################################################################

   task automatic check_reg(input string name, input logic [REG_W-1:0] exp,
                            input logic [REG_W-1:0] act);
      checks++;
      if (act !== exp) begin
         value_errs++;
         $display("FAILED %0s: expected %08h, actual %08h", name, exp, act);
      end
   endtask

   task automatic check_freq(input string name, input logic [CNT_W-1:0] exp,
                             input logic [CNT_W-1:0] act);
      int diff;
      diff = int'(act) - int'(exp);
      checks++;
      if ($isunknown(act) || diff > 1 || diff < -1) begin   // edge phase gives +-1
         value_errs++;
         $display("FAILED %0s: expected %0d, actual %0d", name, exp, act);
      end
   endtask

   task automatic poll_reg(input string name, input logic [ADDR_W-1:0] a,
                           input logic [REG_W-1:0] mask, input logic [REG_W-1:0] exp);
      logic [REG_W-1:0] d;
      int               tries;
      tries = 0;
      reg_read(a, d);
      while (((d & mask) !== exp) && (tries < POLL_MAX)) begin
         tries++;
         reg_read(a, d);
      end
      if ((d & mask) !== exp) begin
         other_errs++;
         $display("%0s: register never showed %08h under mask %08h, last read %08h",
                  name, exp, mask, d);
      end
   endtask

   // ########################################################################
   // trace handling
   // ########################################################################

   function automatic int kind_code(input logic [63:0] kind);
      case (kind)
         "wr":    return OP_WR;
         "rd":    return OP_RD;
         "fq":    return OP_FQ;
         "wait":  return OP_WAIT;
         "poll":  return OP_POLL;
         default: return -1;
      endcase
   endfunction

   task automatic load_trace();
      int               fd;
      int               n;
      int               lineno;
      int               code;
      logic [8*128-1:0] line_buf;
      logic [63:0]      kind;
      logic [REG_W-1:0] a;
      logic [REG_W-1:0] d;
      logic [REG_W-1:0] e;
      lineno = 0;
      fd = $fopen("tb/clkgen_trace.txt", "r");
      if (fd == 0) begin
         other_errs++;
         $display("could not open the trace file tb/clkgen_trace.txt");
         return;
      end
      line_buf = '0;
      while ($fgets(line_buf, fd) != 0) begin
         lineno++;
         kind = '0;
         n    = $sscanf(line_buf, "%s %h %h %h", kind, a, d, e);
         if (n == 4 && kind != "#") begin   // comments and blank lines skipped
            code = kind_code(kind);
            if (code < 0 || n_ops == MAX_OPS) begin
               other_errs++;
               $display("trace line %0d has an unknown kind or exceeds the table", lineno);
            end else begin
               op_kind[n_ops] = code;
               op_line[n_ops] = lineno;
               op_addr[n_ops] = a[ADDR_W-1:0];
               op_data[n_ops] = d;
               op_exp[n_ops]  = e;
               n_ops++;
            end
         end
         line_buf = '0;
      end
      $fclose(fd);
      if (n_ops == 0) begin
         other_errs++;
         $display("the trace file holds no operations");
      end
   endtask

   // twice the waits, pin windows and a lock budget per start
   function automatic int run_budget();
      int cycles;
      cycles = 2 * RST_CYCLES;
      for (int i = 0; i < n_ops; i++) begin
         cycles += 4;   // bus overhead per op
         if (op_kind[i] == OP_WAIT)
            cycles += int'(op_data[i]);
         if (op_kind[i] == OP_FQ)
            cycles += WINDOW + 2;
         if (op_kind[i] == OP_WR && op_addr[i] == ADDR_CTRL && op_data[i][0])
            cycles += LOCK_TIMEOUT;
      end
      return 2 * cycles;
   endfunction

   task automatic run_op(input int i);
      logic [REG_W-1:0] d;
      logic [CNT_W-1:0] n;
      string            name;
      name = $sformatf("trace line %0d addr %0h", op_line[i], op_addr[i]);
      case (op_kind[i])
         OP_WR: reg_write(op_addr[i], op_data[i]);
         OP_RD: begin
            reg_read(op_addr[i], d);
            check_reg(name, op_exp[i], d);
         end
         OP_FQ: begin
            reg_read(op_addr[i], d);
            check_freq(name, op_exp[i][CNT_W-1:0], d[CNT_W-1:0]);
            // same count measured on the clkout pin itself
            count_pin_edges((op_addr[i] == ADDR_FREQ1) ? 1 : 0, n);
            check_freq({name, " pin"}, op_exp[i][CNT_W-1:0], n);
         end
         OP_WAIT: repeat (op_data[i]) @(posedge clk);
         OP_POLL: poll_reg(name, op_addr[i], op_data[i], op_exp[i]);
         default: ;
      endcase
   endtask

   task automatic print_counts();
      $display("checks %0d, value errors %0d, other errors %0d",
               checks, value_errs, other_errs);
   endtask

   // ########################################################################
   // main sequence and watchdog
   // ########################################################################

   initial begin
      clk          = 1'b0;
      clk_half     = 1'b0;
      rst_n        = 1'b0;
      wr_en        = 1'b0;
      rd_en        = 1'b0;
      addr         = '0;
      wdata        = '0;
      checks       = 0;
      value_errs   = 0;
      other_errs   = 0;
      n_ops        = 0;
      budget_ready = 1'b0;
      load_trace();
      budget       = run_budget();
      budget_ready = 1'b1;
      repeat (RST_CYCLES) @(posedge clk);   // 8 clocks in reset
      rst_n <= 1'b1;
      for (int i = 0; i < n_ops; i++) begin
         run_op(i);
      end
      repeat (4) @(posedge clk);
      print_counts();
      if (value_errs == 0 && other_errs == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

   initial begin
      wait (budget_ready);
      repeat (budget) @(posedge clk);
      other_errs++;
      $display("watchdog expired after %0d clocks before the trace finished", budget);
      print_counts();
      $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
common/clkgen_pkg.sv
pll/la_pll.sv
verilog/clkgen_regs.sv
verilog/pll_sequencer.sv
verilog/freq_meter.sv
verilog/clkgen_top.sv
tb/tb_clkgen.sv

// ==== verilog/clkgen_regs.sv ====
// register file for pll programming, control bits, status and measured counts
`timescale 1ns/1ps
`default_nettype none

module clkgen_regs (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          wr_en,
   input  logic                          rd_en,
   input  logic [clkgen_pkg::ADDR_W-1:0] addr,
   input  logic [clkgen_pkg::REG_W-1:0]  wdata,
   output logic [clkgen_pkg::REG_W-1:0]  rdata,
   output clkgen_pkg::cfg_word_u         div_cfg,
   output clkgen_pkg::cfg_word_u         out_cfg,
   output logic                          bypass,
   output logic [clkgen_pkg::NIN-1:0]    clksel,
   output logic                          start,      // one cycle pulse
   input  logic                          ready,
   input  logic                          freqlock,   // synchronized copy
   input  logic                          phaselock,  // synchronized copy
   input  logic                          timeout,
   input  logic                          lock_lost,
   input  logic [clkgen_pkg::CNT_W-1:0]  freq0,
   input  logic [clkgen_pkg::CNT_W-1:0]  freq1,
   input  logic                          meas_valid
);
   import clkgen_pkg::*;

   logic             wr_div;
   logic             wr_out;
   logic             wr_ctrl;
   logic [REG_W-1:0] rd_mux;

   assign wr_div  = wr_en && (addr == ADDR_DIV);
   assign wr_out  = wr_en && (addr == ADDR_OUT);
   assign wr_ctrl = wr_en && (addr == ADDR_CTRL);

   // ########################################################################
   // write side
   // ########################################################################

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         div_cfg <= DIV_RST;
         out_cfg <= OUT_RST;
         bypass  <= 1'b0;
         clksel  <= CLKSEL_RST;
         start   <= 1'b0;
      end else begin
         start <= wr_ctrl && wdata[0];   // self clearing
         if (wr_div) begin
            div_cfg <= wdata;
         end
         if (wr_out) begin
            out_cfg <= wdata;
         end
         if (wr_ctrl) begin
            bypass <= wdata[1];
            clksel <= wdata[2 +: NIN];   // bits 3:2
         end
      end
   end

   // ########################################################################
   // read side
   // ########################################################################

   always_comb begin
      rd_mux = '0;
      case (addr)
         ADDR_DIV:   rd_mux = div_cfg;
         ADDR_OUT:   rd_mux = out_cfg;
         ADDR_CTRL:  rd_mux = REG_W'({clksel, bypass, 1'b0});   // start reads 0
         ADDR_STAT:  rd_mux = REG_W'({lock_lost, timeout, phaselock, freqlock, ready});
         ADDR_FREQ0: rd_mux = meas_valid ? REG_W'(freq0) : '0;
         ADDR_FREQ1: rd_mux = meas_valid ? REG_W'(freq1) : '0;
         default:    rd_mux = '0;
      endcase
   end

   // rdata holds between reads
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rdata <= rd_mux;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/clkgen_top.sv ====
// clock generation top, ties the register block, sequencer, pll and frequency meter together
`timescale 1ns/1ps
`default_nettype none

module clkgen_top (
   input  logic                          clk,      // system clock
   input  logic                          rst_n,
   input  logic [clkgen_pkg::NIN-1:0]    clkin,    // reference clocks
   input  logic                          wr_en,
   input  logic                          rd_en,
   input  logic [clkgen_pkg::ADDR_W-1:0] addr,
   input  logic [clkgen_pkg::REG_W-1:0]  wdata,
   output logic [clkgen_pkg::REG_W-1:0]  rdata,
   output logic [clkgen_pkg::NOUT-1:0]   clkout
);
   import clkgen_pkg::*;

   cfg_word_u        div_cfg;
   cfg_word_u        out_cfg;
   logic             bypass;
   logic [NIN-1:0]   clksel;
   logic             start;
   logic             pll_reset;
   logic             pll_en;
   logic             ready;
   logic             timeout;
   logic             lock_lost;
   logic             freqlock;        // pll side, async
   logic             phaselock;
   logic             freqlock_sync;   // clk side
   logic             phaselock_sync;
   logic [CNT_W-1:0] freq0;
   logic [CNT_W-1:0] freq1;
   logic             meas_valid;

   // ########################################################################
   // control
   // ########################################################################

   clkgen_regs i_regs (
      .clk        (clk),
      .rst_n      (rst_n),
      .wr_en      (wr_en),
      .rd_en      (rd_en),
      .addr       (addr),
      .wdata      (wdata),
      .rdata      (rdata),
      .div_cfg    (div_cfg),
      .out_cfg    (out_cfg),
      .bypass     (bypass),
      .clksel     (clksel),
      .start      (start),
      .ready      (ready),
      .freqlock   (freqlock_sync),
      .phaselock  (phaselock_sync),
      .timeout    (timeout),
      .lock_lost  (lock_lost),
      .freq0      (freq0),
      .freq1      (freq1),
      .meas_valid (meas_valid)
   );

   pll_sequencer i_seq (
      .clk            (clk),
      .rst_n          (rst_n),
      .start          (start),
      .freqlock       (freqlock),
      .phaselock      (phaselock),
      .pll_reset      (pll_reset),
      .pll_en         (pll_en),
      .ready          (ready),
      .timeout        (timeout),
      .lock_lost      (lock_lost),
      .freqlock_sync  (freqlock_sync),
      .phaselock_sync (phaselock_sync)
   );

   // ########################################################################
   // clocks
   // ########################################################################

   la_pll i_pll (
      .clkin     (clkin),
      .clksel    (clksel),
      .reset     (pll_reset),
      .en        (pll_en),
      .bypass    (bypass),
      .div_cfg   (div_cfg),
      .out_cfg   (out_cfg),
      .clkvco    (),            // not brought out
      .clkout    (clkout),
      .freqlock  (freqlock),
      .phaselock (phaselock)
   );

   freq_meter i_meter (
      .clk        (clk),
      .rst_n      (rst_n),
      .clkout     (clkout),
      .freq0      (freq0),
      .freq1      (freq1),
      .meas_valid (meas_valid)
   );

endmodule

`default_nettype wire

// ==== verilog/freq_meter.sv ====
// counts rising edges of each pll output over a fixed window of system clocks
`timescale 1ns/1ps
`default_nettype none

module freq_meter (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic [clkgen_pkg::NOUT-1:0]  clkout,      // async to clk
   output logic [clkgen_pkg::CNT_W-1:0] freq0,
   output logic [clkgen_pkg::CNT_W-1:0] freq1,
   output logic                         meas_valid   // after first full window
);
   import clkgen_pkg::*;

   logic [NOUT-1:0]            sync1;
   logic [NOUT-1:0]            sync2;
   logic [NOUT-1:0]            sync3;     // previous sample for edge detect
   logic [NOUT-1:0]            rise;
   logic [WIN_W-1:0]           win_cnt;
   logic                       win_end;
   logic [NOUT-1:0][CNT_W-1:0] edge_cnt;  // running count
   logic [NOUT-1:0][CNT_W-1:0] total;     // latched per window

   // sync and edge detect, good up to clk/2
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         sync1 <= '0;
         sync2 <= '0;
         sync3 <= '0;
      end else begin
         sync1 <= clkout;
         sync2 <= sync1;
         sync3 <= sync2;
      end
   end

   assign rise    = sync2 & ~sync3;
   assign win_end = (win_cnt == WIN_W'(WINDOW - 1));

   // ########################################################################
   // window and edge counters
   // ########################################################################

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         win_cnt    <= '0;
         edge_cnt   <= '0;
         meas_valid <= 1'b0;
      end else begin
         win_cnt    <= win_end ? '0 : win_cnt + 1'b1;
         meas_valid <= meas_valid | win_end;
         for (int i = 0; i < NOUT; i++) begin
            edge_cnt[i] <= win_end ? '0 : edge_cnt[i] + CNT_W'(rise[i]);
         end
      end
   end

   // last cycle's edge belongs to the closing window
   always_ff @(posedge clk) begin
      if (win_end) begin
         for (int i = 0; i < NOUT; i++) begin
            total[i] <= edge_cnt[i] + CNT_W'(rise[i]);
         end
      end
   end

   assign freq0 = total[0];
   assign freq1 = total[1];

endmodule

`default_nettype wire

// ==== verilog/pll_sequencer.sv ====
// power-up FSM that resets and enables the pll, waits for lock and flags timeout or lock loss
`timescale 1ns/1ps
`default_nettype none

module pll_sequencer (
   input  logic clk,
   input  logic rst_n,
   input  logic start,           // restarts from any state
   input  logic freqlock,        // async, from pll
   input  logic phaselock,       // async, from pll
   output logic pll_reset,
   output logic pll_en,
   output logic ready,
   output logic timeout,         // sticky until next start
   output logic lock_lost,       // sticky until next start
   output logic freqlock_sync,
   output logic phaselock_sync
);
   import clkgen_pkg::*;

   logic [1:0]       fl_sync;
   logic [1:0]       pl_sync;
   logic             both_lock;
   logic [ST_W-1:0]  state;
   logic [SEQ_W-1:0] cnt;       // reset hold, then lock wait

   // two flop synchronizers
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         fl_sync <= '0;
         pl_sync <= '0;
      end else begin
         fl_sync <= {fl_sync[0], freqlock};
         pl_sync <= {pl_sync[0], phaselock};
      end
   end

   assign freqlock_sync  = fl_sync[1];
   assign phaselock_sync = pl_sync[1];
   assign both_lock      = freqlock_sync && phaselock_sync;

   // ########################################################################
   // FSM
   // ########################################################################

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state     <= ST_IDLE;
         cnt       <= '0;
         timeout   <= 1'b0;
         lock_lost <= 1'b0;
      end else if (start) begin
         state     <= ST_RESET;
         cnt       <= '0;
         timeout   <= 1'b0;
         lock_lost <= 1'b0;
      end else begin
         case (state)
            ST_RESET: begin
               if (cnt == SEQ_W'(RST_CYCLES - 1)) begin
                  state <= ST_WAIT;
                  cnt   <= '0;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            ST_WAIT: begin
               if (both_lock) begin
                  state <= ST_LOCKED;
               end else if (cnt == SEQ_W'(LOCK_TIMEOUT - 1)) begin
                  state   <= ST_FAULT;
                  timeout <= 1'b1;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            ST_LOCKED: begin
               if (!both_lock) begin   // either flag dropped
                  state     <= ST_FAULT;
                  lock_lost <= 1'b1;
               end
            end
            default: ;   // idle and fault wait for start
         endcase
      end
   end

   assign pll_reset = (state == ST_IDLE) || (state == ST_RESET);
   assign pll_en    = !pll_reset;   // stays on in fault
   assign ready     = (state == ST_LOCKED);

endmodule

`default_nettype wire
